// ==== design/frog_macros.svh ====
`ifndef FROG_MACROS_SVH
`define FROG_MACROS_SVH

// pixel coordinate width, enough for a 640 x 480 field
`define FROG_COORD_W 10

// one grid cell, also the frog's size
`define FROG_BLOCK 32

// obstacle positions wrap at the screen width
`define FROG_SCREEN_W 640

// six river lanes and six road lanes
`define FROG_LANES 12
`define FROG_MAX_OBJ 3

// home square, bottom row in the middle
`define FROG_START_X 320
`define FROG_START_Y 448

// playable columns
`define FROG_FIELD_LEFT 96
`define FROG_FIELD_RIGHT 576

// water band, rows 1 to 6
`define FROG_RIVER_TOP 32
`define FROG_RIVER_BOTTOM 224

`endif

// ==== design/frog_pkg.sv ====
`include "frog_macros.svh"

package frog_pkg;

    typedef logic [`FROG_COORD_W-1:0] coord_t;

    typedef enum logic [1:0] {
        UP,
        DOWN,
        LEFT,
        RIGHT
    } dir_e;

    typedef enum logic [1:0] {
        MENU,
        PLAYING,
        DEAD,
        WIN
    } state_e;

    typedef enum logic {
        RIVER,
        ROAD
    } lane_kind_e;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // request side of the move handshake
    typedef struct packed {
        logic req;
        dir_e dir;
    } move_req_t;

    typedef struct packed {
        state_e     state;
        logic [3:0] level;
    } game_status_t;

    // constants for one lane
    typedef struct packed {
        lane_kind_e kind;
        logic [3:0] row;
        logic [1:0] count;
        coord_t     len;
        logic [3:0] speed;
        logic       leftward;
        coord_t     offset;
    } lane_cfg_t;

    // lane table: kind, row, count, length, speed, leftward, offset
    function automatic lane_cfg_t lane_cfg(input int unsigned idx);
        lane_cfg_t cfg;
        case (idx)
            // logs
            0:  cfg = '{RIVER, 4'd1,  2'd3, 10'd64, 4'd1, 1'b0, 10'd0};
            1:  cfg = '{RIVER, 4'd2,  2'd2, 10'd96, 4'd2, 1'b1, 10'd40};
            2:  cfg = '{RIVER, 4'd3,  2'd3, 10'd64, 4'd1, 1'b1, 10'd100};
            3:  cfg = '{RIVER, 4'd4,  2'd2, 10'd96, 4'd3, 1'b0, 10'd200};
            4:  cfg = '{RIVER, 4'd5,  2'd2, 10'd80, 4'd2, 1'b1, 10'd60};
            5:  cfg = '{RIVER, 4'd6,  2'd3, 10'd64, 4'd1, 1'b0, 10'd300};
            // cars
            6:  cfg = '{ROAD,  4'd8,  2'd1, 10'd64, 4'd2, 1'b1, 10'd0};
            7:  cfg = '{ROAD,  4'd9,  2'd2, 10'd32, 4'd3, 1'b0, 10'd150};
            8:  cfg = '{ROAD,  4'd10, 2'd1, 10'd48, 4'd4, 1'b1, 10'd500};
            9:  cfg = '{ROAD,  4'd11, 2'd2, 10'd32, 4'd1, 1'b0, 10'd320};
            10: cfg = '{ROAD,  4'd12, 2'd2, 10'd64, 4'd2, 1'b1, 10'd80};
            11: cfg = '{ROAD,  4'd13, 2'd1, 10'd32, 4'd3, 1'b0, 10'd250};
            // no obstacles outside the table
            default: cfg = '0;
        endcase
        return cfg;
    endfunction

endpackage

// ==== design/frog_mover.sv ====
`include "frog_macros.svh"

module frog_mover (
    input  logic                osc_25_1M,
    input  logic                rst,
    input  frog_pkg::move_req_t move,
    input  logic                hold,
    input  logic                home,
    output logic                move_ack,
    output logic                move_taken,
    output frog_pkg::pos_t      frog_pos
);
    import frog_pkg::*;

    localparam coord_t BLOCK = coord_t'(`FROG_BLOCK);
    localparam coord_t START_Y = coord_t'(`FROG_START_Y);
    localparam pos_t START_POS = '{
        x: coord_t'(`FROG_START_X),
        y: START_Y
    };

    logic accept;
    pos_t step_pos;

    // fresh request while idle is the acceptance condition
    assign accept = move.req && !move_ack;

    // one grid step in the requested direction
    always_comb begin
        step_pos = frog_pos;
        case (move.dir)
            UP: begin
                step_pos.y = frog_pos.y - BLOCK;
            end
            DOWN: begin
                // bottom row is the floor
                if (frog_pos.y != START_Y) begin
                    step_pos.y = frog_pos.y + BLOCK;
                end
            end
            LEFT: begin
                step_pos.x = frog_pos.x - BLOCK;
            end
            RIGHT: begin
                step_pos.x = frog_pos.x + BLOCK;
            end
            default: begin
                step_pos = frog_pos;
            end
        endcase
    end

    // four-phase req/ack, ack follows req one edge later
    always_ff @(posedge osc_25_1M) begin
        if (rst) begin
            move_ack   <= 1'b0;
            move_taken <= 1'b0;
        end else begin
            move_taken <= accept;
            if (accept) begin
                move_ack <= 1'b1;
            end else if (!move.req) begin
                move_ack <= 1'b0;
            end
        end
    end

    // position register
    always_ff @(posedge osc_25_1M) begin
        if (rst) begin
            frog_pos <= START_POS;
        end else if (home) begin
            // sent back after a death or a win
            frog_pos <= START_POS;
        end else if (accept && !hold) begin
            frog_pos <= step_pos;
        end
    end

endmodule

// ==== design/lane_hazard.sv ====
`include "frog_macros.svh"

module lane_hazard #(
    parameter int LANE = 0
) (
    input  logic           osc_25_1M,
    input  logic           rst,
    input  logic           frame_tick,
    input  frog_pkg::pos_t frog_pos,
    output logic           hit
);
    import frog_pkg::*;

    localparam lane_cfg_t CFG = lane_cfg(LANE);
    localparam coord_t BLOCK = coord_t'(`FROG_BLOCK);
    localparam coord_t SCREEN_W = coord_t'(`FROG_SCREEN_W);
    localparam coord_t SPEED = coord_t'(CFG.speed);

    coord_t obj_x [`FROG_MAX_OBJ];
    logic [`FROG_MAX_OBJ-1:0] obj_hit;
    coord_t frog_row;
    logic row_match;

    // obstacles spread evenly over the screen width
    function automatic coord_t start_x(input int k);
        int pos;
        if (CFG.count == 2'd0) begin
            pos = int'(CFG.offset);
        end else begin
            pos = int'(CFG.offset) + (k * `FROG_SCREEN_W) / int'(CFG.count);
            pos = pos % `FROG_SCREEN_W;
        end
        return coord_t'(pos);
    endfunction

    // one frame of motion, wrapping at the screen edge
    function automatic coord_t advance(input coord_t x);
        coord_t nx;
        if (CFG.leftward) begin
            if (x < SPEED) begin
                nx = x + SCREEN_W - SPEED;
            end else begin
                nx = x - SPEED;
            end
        end else begin
            nx = x + SPEED;
            if (nx >= SCREEN_W) begin
                nx = nx - SCREEN_W;
            end
        end
        return nx;
    endfunction

    always_ff @(posedge osc_25_1M) begin
        if (rst) begin
            for (int k = 0; k < `FROG_MAX_OBJ; k++) begin
                obj_x[k] <= start_x(k);
            end
        end else if (frame_tick) begin
            for (int k = 0; k < `FROG_MAX_OBJ; k++) begin
                obj_x[k] <= advance(obj_x[k]);
            end
        end
    end

    // grid row of the frog
    assign frog_row = frog_pos.y / BLOCK;
    assign row_match = (frog_row == coord_t'(CFG.row));

    // box overlap per obstacle, plain compares with no wrap
    always_comb begin
        for (int k = 0; k < `FROG_MAX_OBJ; k++) begin
            obj_hit[k] = (k < int'(CFG.count))
                      && (frog_pos.x < obj_x[k] + CFG.len)
                      && (frog_pos.x + BLOCK > obj_x[k]);
        end
    end

    assign hit = row_match && (|obj_hit);

endmodule

// ==== design/game_judge.sv ====
`include "frog_macros.svh"

module game_judge (
    input  logic                   osc_25_1M,
    input  logic                   rst,
    input  logic [`FROG_LANES-1:0] hits,
    input  frog_pkg::pos_t         frog_pos,
    input  logic                   move_taken,
    output logic                   hold,
    output logic                   home,
    output frog_pkg::game_status_t status
);
    import frog_pkg::*;

    // lanes of one kind as a bit mask
    function automatic logic [`FROG_LANES-1:0] kind_mask(input lane_kind_e kind);
        logic [`FROG_LANES-1:0] mask;
        lane_cfg_t cfg;
        mask = '0;
        for (int i = 0; i < `FROG_LANES; i++) begin
            cfg = lane_cfg(i);
            mask[i] = (cfg.kind == kind);
        end
        return mask;
    endfunction

    localparam logic [`FROG_LANES-1:0] ROAD_MASK = kind_mask(ROAD);
    localparam logic [`FROG_LANES-1:0] RIVER_MASK = kind_mask(RIVER);
    localparam coord_t BLOCK = coord_t'(`FROG_BLOCK);

    state_e state_q;
    logic [3:0] level_q;
    logic end_pend;
    logic road_hit;
    logic river_hit;
    logic in_water;
    logic past_border;
    logic at_top;
    logic die;

    assign road_hit = |(hits & ROAD_MASK);
    assign river_hit = |(hits & RIVER_MASK);

    // in the water band and not on a log
    assign in_water = (frog_pos.y >= coord_t'(`FROG_RIVER_TOP))
                   && (frog_pos.y < coord_t'(`FROG_RIVER_BOTTOM))
                   && !river_hit;

    // fully off the left side, or onto the right border
    assign past_border = (frog_pos.x + BLOCK <= coord_t'(`FROG_FIELD_LEFT))
                      || (frog_pos.x >= coord_t'(`FROG_FIELD_RIGHT));

    assign die = road_hit || in_water || past_border;
    assign at_top = (frog_pos.y < BLOCK);

    always_ff @(posedge osc_25_1M) begin
        if (rst) begin
            state_q  <= MENU;
            level_q  <= '0;
            end_pend <= 1'b0;
            home     <= 1'b0;
        end else begin
            end_pend <= 1'b0;
            // frog goes home one edge after the round ends
            home <= end_pend;
            case (state_q)
                PLAYING: begin
                    // death wins over reaching the top
                    if (die) begin
                        state_q  <= DEAD;
                        end_pend <= 1'b1;
                    end else if (at_top) begin
                        state_q  <= WIN;
                        level_q  <= level_q + 4'd1;
                        end_pend <= 1'b1;
                    end
                end
                default: begin
                    // any move starts the next round
                    if (move_taken) begin
                        state_q <= PLAYING;
                    end
                end
            endcase
        end
    end

    // frog frozen outside a round
    assign hold = (state_q != PLAYING);

    assign status.state = state_q;
    assign status.level = level_q;

endmodule

// ==== design/frog_top.sv ====
`include "frog_macros.svh"

module frog_top (
    input  logic                   osc_25_1M,
    input  logic                   rst,
    input  logic                   frame_tick,
    input  frog_pkg::move_req_t    move,
    output logic                   move_ack,
    output frog_pkg::game_status_t status,
    output frog_pkg::pos_t         frog
);

    logic [`FROG_LANES-1:0] hits;
    logic move_taken;
    logic hold;
    logic home;

    // handshake and frog position
    frog_mover i_mover (
        .osc_25_1M  (osc_25_1M),
        .rst        (rst),
        .move       (move),
        .hold       (hold),
        .home       (home),
        .move_ack   (move_ack),
        .move_taken (move_taken),
        .frog_pos   (frog)
    );

    // one obstacle lane per row, config picked by index
    for (genvar i = 0; i < `FROG_LANES; i++) begin : g_lane
        lane_hazard #(
            .LANE (i)
        ) i_lane (
            .osc_25_1M  (osc_25_1M),
            .rst        (rst),
            .frame_tick (frame_tick),
            .frog_pos   (frog),
            .hit        (hits[i])
        );
    end

    // hit collection and game states
    game_judge i_judge (
        .osc_25_1M  (osc_25_1M),
        .rst        (rst),
        .hits       (hits),
        .frog_pos   (frog),
        .move_taken (move_taken),
        .hold       (hold),
        .home       (home),
        .status     (status)
    );

endmodule

// ==== verif/frog_tests.svh ====
`ifndef FROG_TESTS_SVH
`define FROG_TESTS_SVH

task automatic tick_frames(input int n);
    repeat (n) begin
        @(negedge osc_25_1M);
        frame_tick = 1'b1;
        @(negedge osc_25_1M);
        frame_tick = 1'b0;
        model_tick();
    end
endtask

// full four-phase move checked two cycles after ack falls
task automatic do_move(input dir_e d);
    int n;
    @(negedge osc_25_1M);
    move = '{req: 1'b1, dir: d};
    n = 0;
    while (!move_ack && n < 16) begin
        @(negedge osc_25_1M);
        n++;
    end
    if (!move_ack) begin
        $display("move request at t=%0t was never acknowledged", $time);
        errors++;
        test_errors++;
    end
    move.req = 1'b0;
    n = 0;
    while (move_ack && n < 16) begin
        @(negedge osc_25_1M);
        n++;
    end
    if (move_ack) begin
        $display("move_ack still high at t=%0t after the request dropped", $time);
        errors++;
        test_errors++;
    end
    repeat (2) @(negedge osc_25_1M);
    model_move(d);
    check_all();
endtask

// breadth first search over safe cells with grid index row*16+col
task automatic plan_path(input int target, output bit ok);
    int prev [240];
    int q [$];
    int cur;
    int nr;
    int nc;
    int nxt;
    foreach (prev[i]) prev[i] = -1;
    path.delete();
    ok = 1'b0;
    cur = (exp_y / 32) * 16 + (exp_x - 96) / 32;
    prev[cur] = cur;
    q.push_back(cur);
    while (q.size() > 0 && !ok) begin
        cur = q.pop_front();
        if (cur / 16 == target) begin
            ok = 1'b1;
        end else begin
            for (int d = 0; d < 4; d++) begin
                nr = cur / 16 + ((d == 0) ? -1 : (d == 1) ? 1 : 0);
                nc = cur % 16 + ((d == 2) ? -1 : (d == 3) ? 1 : 0);
                nxt = nr * 16 + nc;
                if (nr >= target && nr <= 14 && nc >= 0 && nc <= 14
                        && prev[nxt] < 0 && !kills(96 + 32 * nc, 32 * nr)) begin
                    prev[nxt] = cur;
                    q.push_back(nxt);
                end
            end
        end
    end
    while (ok && cur != prev[cur]) begin
        case (cur - prev[cur])
            -16: path.push_front(UP);
            16: path.push_front(DOWN);
            -1: path.push_front(LEFT);
            default: path.push_front(RIGHT);
        endcase
        cur = prev[cur];
    end
endtask

// waits at home with frame ticks until a safe path exists
task automatic climb_to(input int target);
    bit ok;
    int tries;
    tries = 0;
    plan_path(target, ok);
    while (!ok && tries < 300) begin
        tick_frames(1);
        plan_path(target, ok);
        tries++;
    end
    if (!ok) begin
        $display("no safe path to row %0d found", target);
        errors++;
        test_errors++;
    end
    foreach (path[i]) do_move(path[i]);
endtask

task automatic slide_to_log(input bit want_log);
    int c;
    c = 0;
    while (c < 15 && model_hit(96 + 32 * c, 192) != want_log) c++;
    if (c == 15) begin
        $display("no column with log=%0d on row 6", want_log);
        errors++;
        test_errors++;
        c = 7;
    end
    while (exp_x > 96 + 32 * c) do_move(LEFT);
    while (exp_x < 96 + 32 * c) do_move(RIGHT);
endtask

task automatic run_tests();
    int n;
    bit pred;
    check_all();
    check("move_ack", 0, int'(move_ack));
    do_move(UP);
    check("status.state", int'(PLAYING), int'(status.state));
    end_test("reset_handshake");

    do_move(LEFT);
    do_move(RIGHT);
    do_move(DOWN);
    end_test("movement");

    n = 0;
    while (!model_hit(exp_x, 416) && n < 700) begin
        tick_frames(1);
        n++;
    end
    do_move(UP);
    check("status.state", int'(DEAD), int'(status.state));
    do_move(UP);
    end_test("road_death");

    climb_to(7);
    slide_to_log(1'b1);
    do_move(UP);
    check("status.state", int'(PLAYING), int'(status.state));
    do_move(DOWN);
    slide_to_log(1'b0);
    do_move(UP);
    check("status.state", int'(DEAD), int'(status.state));
    do_move(UP);
    // x reaches 64, fully past the left border
    repeat (8) do_move(LEFT);
    check("status.state", int'(DEAD), int'(status.state));
    do_move(UP);
    end_test("water_border");

    climb_to(0);
    check("status.state", int'(WIN), int'(status.state));
    check("status.level", 1, int'(status.level));
    do_move(UP);
    check("status.state", int'(PLAYING), int'(status.state));
    end_test("win_level");

    repeat (4) begin
        tick_frames(rand_below(40) + 1);
        if (rand_below(2) == 0) begin
            do_move(LEFT);
        end else begin
            do_move(RIGHT);
        end
        pred = model_hit(exp_x, 416);
        do_move(UP);
        check("status.state", pred ? int'(DEAD) : int'(PLAYING), int'(status.state));
        // back to home row either way
        if (pred) begin
            do_move(UP);
        end else begin
            do_move(DOWN);
        end
    end
    end_test("obstacle_motion");
endtask

`endif

// ==== verif/frog_tb.sv ====
`include "frog_macros.svh"

module frog_tb;
    import frog_pkg::*;

    // per-test cycle budgets summed with a margin of two
    localparam int BUDGET = 2 * (100 + 100 + 1500 + 2500 + 2000 + 1000);

    logic osc_25_1M;
    logic rst;
    logic frame_tick;
    move_req_t move;
    logic move_ack;
    game_status_t status;
    pos_t frog;

    // lane table in columns row, count, length, speed, leftward and offset
    int lane_row [12] = '{1, 2, 3, 4, 5, 6, 8, 9, 10, 11, 12, 13};
    int lane_cnt [12] = '{3, 2, 3, 2, 2, 3, 1, 2, 1, 2, 2, 1};
    int lane_len [12] = '{64, 96, 64, 96, 80, 64, 64, 32, 48, 32, 64, 32};
    int lane_spd [12] = '{1, 2, 1, 3, 2, 1, 2, 3, 4, 1, 2, 3};
    int lane_lft [12] = '{0, 1, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};
    int lane_off [12] = '{0, 40, 100, 200, 60, 300, 0, 150, 500, 320, 80, 250};

    int ox [12][3];
    state_e exp_state;
    int exp_level;
    int exp_x;
    int exp_y;
    int errors;
    int test_errors;
    int tests_ok;
    int tests_bad;
    logic [31:0] rng;
    dir_e path [$];

    frog_top i_dut (
        .osc_25_1M  (osc_25_1M),
        .rst        (rst),
        .frame_tick (frame_tick),
        .move       (move),
        .move_ack   (move_ack),
        .status     (status),
        .frog       (frog)
    );

    always #10 osc_25_1M = ~osc_25_1M;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift(rng);
        return int'(rng % n);
    endfunction

    // any obstacle of the lane on row y/32 covering column x
    function automatic bit model_hit(input int x, input int y);
        for (int l = 0; l < 12; l++) begin
            if (lane_row[l] == y / 32) begin
                for (int k = 0; k < lane_cnt[l]; k++) begin
                    if (x < ox[l][k] + lane_len[l] && x + 32 > ox[l][k]) begin
                        return 1'b1;
                    end
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic bit kills(input int x, input int y);
        bit h;
        h = model_hit(x, y);
        if (x + 32 <= 96 || x >= 576) begin
            return 1'b1;
        end
        // rows 1 to 6 are water and 8 to 13 road
        if (y >= 32 && y < 224) begin
            return !h;
        end
        return h;
    endfunction

    function automatic void model_judge();
        if (exp_state == PLAYING) begin
            if (kills(exp_x, exp_y)) begin
                exp_state = DEAD;
            end else if (exp_y < 32) begin
                exp_state = WIN;
                exp_level = (exp_level + 1) % 16;
            end
            if (exp_state != PLAYING) begin
                exp_x = 320;
                exp_y = 448;
            end
        end
    endfunction

    function automatic void model_tick();
        for (int l = 0; l < 12; l++) begin
            for (int k = 0; k < lane_cnt[l]; k++) begin
                if (lane_lft[l] != 0) begin
                    ox[l][k] = (ox[l][k] + 640 - lane_spd[l]) % 640;
                end else begin
                    ox[l][k] = (ox[l][k] + lane_spd[l]) % 640;
                end
            end
        end
        model_judge();
    endfunction

    function automatic void model_move(input dir_e d);
        if (exp_state != PLAYING) begin
            // a restart move leaves the position frozen
            exp_state = PLAYING;
            return;
        end
        case (d)
            UP: exp_y = exp_y - 32;
            DOWN: exp_y = (exp_y == 448) ? exp_y : exp_y + 32;
            LEFT: exp_x = exp_x - 32;
            default: exp_x = exp_x + 32;
        endcase
        model_judge();
    endfunction

    task automatic check(input string name, input int exp, input int act);
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_all();
        check("status.state", int'(exp_state), int'(status.state));
        check("status.level", exp_level, int'(status.level));
        check("frog.x", exp_x, int'(frog.x));
        check("frog.y", exp_y, int'(frog.y));
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, test_errors);
        if (test_errors == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        test_errors = 0;
    endtask

    `include "frog_tests.svh"

    initial begin
        #(BUDGET * 20);
        $display("timeout: tests did not finish within %0d cycles", BUDGET);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        osc_25_1M = 1'b0;
        rst = 1'b1;
        frame_tick = 1'b0;
        move = '{req: 1'b0, dir: UP};
        rng = 32'h637;
        errors = 0;
        test_errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        exp_state = MENU;
        exp_level = 0;
        exp_x = 320;
        exp_y = 448;
        for (int l = 0; l < 12; l++) begin
            for (int k = 0; k < 3; k++) begin
                ox[l][k] = (lane_off[l] + k * 640 / lane_cnt[l]) % 640;
            end
        end
        repeat (2) @(negedge osc_25_1M);
        rst = 1'b0;
        run_tests();
        $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
+incdir+verif
design/frog_pkg.sv
design/frog_mover.sv
design/lane_hazard.sv
design/game_judge.sv
design/frog_top.sv
verif/frog_tb.sv
